// ==== Makefile ====
# Verilator lint and simulation of the CPU core testbench
VERILATOR ?= verilator
TOP ?= tbCpu
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
BUILD_FLAGS ?= -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+100
FAIL_TEXT ?= STATUS: FAIL
PASS_TEXT ?= STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG) || ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/cpuCore_asserts.sv ====
`timescale 1ns/1ps

module cpuCoreAsserts
(
	input logic clock,
	input logic reset,
	input logic memWriteEnable,
	input logic instructionEnd
);

	// An end is always followed by a fresh fetch
	endPulseOnce: assert property (@(posedge clock) disable iff (reset)
		instructionEnd |=> !instructionEnd)
		else $error("instructionEnd high on two consecutive cycles");

	// One reset edge is enough to clear the sequencer
	quietInReset: assert property (@(posedge clock)
		$past(reset) |-> !memWriteEnable && !instructionEnd)
		else $error("memWriteEnable or instructionEnd high during reset");

	knownWriteEnable: assert property (@(posedge clock) disable iff (reset)
		!$isunknown(memWriteEnable))
		else $error("memWriteEnable unknown after reset");

endmodule

bind gbCpuCore cpuCoreAsserts coreChecks (.clock(clock), .reset(reset),
	.memWriteEnable(memWriteEnable), .instructionEnd(instructionEnd));

// ==== bench/tbCpu.sv ====
`timescale 1ns/1ps

module tbCpu;

	localparam int TestCount = 6;
	localparam int CyclesPerTest = 600;
	localparam int ClockPeriod = 4;

	logic clock;
	logic reset;
	logic [7:0] memReadData = 8'h00;
	logic [15:0] memAddr;
	logic [7:0] memWriteData;
	logic memWriteEnable;
	logic instructionEnd;

	// Program image, copied into the memory model while reset is high
	logic [7:0] image [0:255];
	logic [7:0] mem [0:255];
	logic [15:0] writeAddrs [$];
	logic [7:0] writeBytes [$];
	int loadPtr;
	int errorCount = 0;
	int checkCount = 0;
	integer seed = 94;
	string testName;

	gbCpuCore UUT (.clock(clock), .reset(reset), .memReadData(memReadData),
		.memAddr(memAddr), .memWriteData(memWriteData), .memWriteEnable(memWriteEnable),
		.instructionEnd(instructionEnd));

	initial
	begin
		clock = 1'b0;
		forever #(ClockPeriod / 2) clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// Memory model, one cycle read latency
	////////////////////////////////////////////////////////////
	always @(posedge clock)
	begin
		if (reset)
		begin
			mem <= image;
			writeAddrs.delete();
			writeBytes.delete();
		end
		else if (memWriteEnable)
		begin
			mem[memAddr[7:0]] <= memWriteData;
			writeAddrs.push_back(memAddr);
			writeBytes.push_back(memWriteData);
		end
		memReadData <= mem[memAddr[7:0]];
	end

	task automatic clearImage(input string name);
		testName = name;
		loadPtr = 0;
		for (int i = 0; i < 256; i++)
			image[i] = 8'h00;
	endtask

	// First byte sits in the most significant position
	task automatic emitBytes(input int count, input logic [23:0] bytes);
		for (int i = count - 1; i >= 0; i--)
		begin
			image[loadPtr] = bytes[8 * i +: 8];
			loadPtr++;
		end
	endtask

	task automatic applyReset();
		@(posedge clock);
		reset <= 1'b1;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
	endtask

	// Extra half cycle at the end lets the last store reach the write log
	task automatic runInstructions(input int count);
		int seen;
		seen = 0;
		while (seen < count)
		begin
			@(negedge clock);
			if (instructionEnd)
				seen++;
		end
		@(negedge clock);
	endtask

	task automatic checkValue(input string what, input int expected, input int actual);
		checkCount++;
		assert (expected == actual)
		else
		begin
			errorCount++;
			$display("Error: %s %s expected %0h actual %0h", testName, what, expected, actual);
		end
	endtask

	task automatic checkWrite(input int index, input int addr, input int data);
		checkCount++;
		assert (index < writeAddrs.size())
		else
		begin
			errorCount++;
			$display("%s: store number %0d never reached memory", testName, index + 1);
		end
		if (index < writeAddrs.size())
		begin
			checkValue($sformatf("write %0d address", index), addr, int'(writeAddrs[index]));
			checkValue($sformatf("write %0d data", index), data, int'(writeBytes[index]));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////
	task automatic testAfterReset();
		clearImage("afterReset");
		// Two NOPs and an unmapped opcode
		emitBytes(3, {8'h00, 8'h00, 8'hD3});
		applyReset();
		@(negedge clock);
		checkValue("write enable", 0, int'(memWriteEnable));
		// Fetch address is presented one cycle after reset
		@(negedge clock);
		checkValue("first address", 0, int'(memAddr));
		runInstructions(4);
		checkValue("write count", 0, writeAddrs.size());
	endtask

	task automatic testLoadStore();
		clearImage("loadStore");
		// LD A,5A  LD B,C3  LD HL,12B4  LD (HL),A  LD L,B7  LD (HL),B
		emitBytes(2, {8'h3E, 8'h5A});
		emitBytes(2, {8'h06, 8'hC3});
		emitBytes(3, {8'h21, 8'hB4, 8'h12});
		emitBytes(1, 8'h77);
		emitBytes(2, {8'h2E, 8'hB7});
		emitBytes(1, 8'h70);
		applyReset();
		runInstructions(6);
		checkValue("write count", 2, writeAddrs.size());
		checkWrite(0, 'h12B4, 'h5A);
		checkWrite(1, 'h12B7, 'hC3);
	endtask

	task automatic testAddSub();
		logic [7:0] a, b, c, sum;
		a = 8'($random(seed));
		b = 8'($random(seed));
		c = 8'($random(seed));
		clearImage("addSub");
		emitBytes(2, {8'h3E, a});
		emitBytes(2, {8'h06, b});
		emitBytes(2, {8'h0E, c});
		emitBytes(3, {8'h21, 8'hC0, 8'h00});
		// ADD A,B  LD (HL),A  SUB C  LD L,C1  LD (HL),A
		emitBytes(1, 8'h80);
		emitBytes(1, 8'h77);
		emitBytes(1, 8'h91);
		emitBytes(2, {8'h2E, 8'hC1});
		emitBytes(1, 8'h77);
		applyReset();
		runInstructions(9);
		checkValue("write count", 2, writeAddrs.size());
		sum = a + b;
		checkWrite(0, 'hC0, int'(sum));
		sum = sum - c;
		checkWrite(1, 'hC1, int'(sum));
	endtask

	task automatic testCountDown();
		int n;
		n = 1 + ($random(seed) & 7);
		clearImage("countDown");
		// LD HL,00D0  LD B,n  loop: DEC B  JR NZ,loop  LD (HL),B
		emitBytes(3, {8'h21, 8'hD0, 8'h00});
		emitBytes(2, {8'h06, 8'(n)});
		emitBytes(1, 8'h05);
		emitBytes(2, {8'h20, 8'hFD});
		emitBytes(1, 8'h70);
		applyReset();
		runInstructions(2 + 2 * n);
		checkValue("writes before store", 0, writeAddrs.size());
		runInstructions(1);
		checkValue("write count", 1, writeAddrs.size());
		checkWrite(0, 'hD0, 0);
	endtask

	task automatic testZeroFlag();
		clearImage("zeroFlag");
		emitBytes(2, {8'h3E, 8'h37});
		emitBytes(2, {8'h06, 8'h37});
		emitBytes(2, {8'h0E, 8'h01});
		emitBytes(3, {8'h21, 8'hE0, 8'h00});
		// SUB B gives zero, JR Z jumps over the first store
		emitBytes(1, 8'h90);
		emitBytes(2, {8'h28, 8'h01});
		emitBytes(1, 8'h77);
		emitBytes(1, 8'h81);
		emitBytes(2, {8'h28, 8'h01});
		emitBytes(1, 8'h77);
		// DEC C to zero skips LD (HL),B, INC A clears Z again
		emitBytes(1, 8'h0D);
		emitBytes(2, {8'h28, 8'h01});
		emitBytes(1, 8'h70);
		emitBytes(1, 8'h3C);
		emitBytes(2, {8'h28, 8'h01});
		emitBytes(1, 8'h77);
		applyReset();
		runInstructions(14);
		checkValue("write count", 2, writeAddrs.size());
		checkWrite(0, 'hE0, 'h01);
		checkWrite(1, 'hE0, 'h02);
	endtask

	task automatic testReadHl();
		logic [7:0] value;
		value = 8'($random(seed));
		clearImage("readHl");
		image[8'hF0] = value;
		// LD HL,00F0  LD A,(HL)  INC HL  unmapped D3  LD (HL),A
		emitBytes(3, {8'h21, 8'hF0, 8'h00});
		emitBytes(1, 8'h7E);
		emitBytes(1, 8'h23);
		emitBytes(1, 8'hD3);
		emitBytes(1, 8'h77);
		applyReset();
		runInstructions(5);
		checkValue("write count", 1, writeAddrs.size());
		checkWrite(0, 'hF1, int'(value));
	endtask

	initial
	begin
		reset = 1'b1;
		testAfterReset();
		testLoadStore();
		testAddSub();
		testCountDown();
		testZeroFlag();
		testReadHl();
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(TestCount * CyclesPerTest * ClockPeriod);
		$display("Run stopped by the watchdog, the tests did not finish in time");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== rtl/cpuPkg.sv ====
package cpuPkg;

	localparam int dataWidth = 8;
	localparam int addrWidth = 16;
	localparam int uopAddrWidth = 9;

	////////////////////////////////////////////////////////////
	// Instruction opcodes kept by this core
	////////////////////////////////////////////////////////////
	typedef enum logic [7:0]
	{
		mopNop     = 8'h00,
		mopIncB    = 8'h04,
		mopDecB    = 8'h05,
		mopLdBN    = 8'h06,
		mopIncC    = 8'h0C,
		mopDecC    = 8'h0D,
		mopLdCN    = 8'h0E,
		mopLdDN    = 8'h16,
		mopJrN     = 8'h18,
		mopLdEN    = 8'h1E,
		mopJrNzN   = 8'h20,
		mopLdHlNn  = 8'h21,
		mopIncHl   = 8'h23,
		mopLdHN    = 8'h26,
		mopJrZN    = 8'h28,
		mopLdLN    = 8'h2E,
		mopIncA    = 8'h3C,
		mopDecA    = 8'h3D,
		mopLdAN    = 8'h3E,
		mopLdHlmB  = 8'h70,
		mopLdHlmA  = 8'h77,
		mopLdAHlm  = 8'h7E,
		mopAddAB   = 8'h80,
		mopAddAC   = 8'h81,
		mopSubB    = 8'h90,
		mopSubC    = 8'h91
	} opcode_t;

	////////////////////////////////////////////////////////////
	// Microcode word fields
	////////////////////////////////////////////////////////////
	typedef enum logic [2:0]
	{
		flowNext, flowIncPc, flowEnd, flowIncPcEnd,
		flowIncPcEndIfZ, flowIncPcEndIfNz, flowUpdateFlags
	} uopFlow_t;

	typedef enum logic [3:0]
	{
		opNop, opSetMemAddr, opLoadFromMem, opMemWrite, opInc, opDec,
		opLoadScratch, opStoreScratch, opAddScratch, opSubScratch, opSetPc
	} uopOp_t;

	// regX8 reads the memory data byte, regX16 names the scratch register
	typedef enum logic [3:0]
	{
		regA, regB, regC, regD, regE, regH, regL, regHl,
		regPc, regX8, regX16, regNone
	} regSel_t;

	typedef struct packed
	{
		uopFlow_t flow;
		uopOp_t   op;
		regSel_t  operand;
	} uop_t;

	typedef enum logic [1:0]
	{
		seqFetchAddr, seqFetchWait, seqDecode, seqExecute
	} seqState_t;

endpackage

// ==== rtl/gbCpuCore.sv ====
`timescale 1ns/1ps

module gbCpuCore
(
	input  logic                          clock,
	input  logic                          reset,
	input  logic [cpuPkg::dataWidth-1:0]  memReadData,
	output logic [cpuPkg::addrWidth-1:0]  memAddr,
	output logic [cpuPkg::dataWidth-1:0]  memWriteData,
	output logic                          memWriteEnable,
	output logic                          instructionEnd
);

	// Microcode words in use, rounded up
	localparam int FlowCount = 72;

	uopIf uopBus();

	cpuPkg::opcode_t opcode;
	cpuPkg::uop_t uop;
	logic [cpuPkg::uopAddrWidth-1:0] flowStart, uopAddr;
	logic [cpuPkg::addrWidth-1:0] operandValue, aluResult;
	logic fetchAddr, aluWrite;

	microSequencer #(.FlowCount(FlowCount)) sequencer (.clock(clock), .reset(reset),
		.memReadData(memReadData), .seq(uopBus.sequencer), .fetchAddr(fetchAddr),
		.flowStart(flowStart), .opcode(opcode), .uopAddr(uopAddr), .uop(uop),
		.instructionEnd(instructionEnd));

	opcodeMap lookup (.opcode(opcode), .flowStart(flowStart));

	microcodeRom #(.FlowCount(FlowCount)) rom (.uopAddr(uopAddr), .uop(uop));

	registerFile regs (.clock(clock), .reset(reset), .dp(uopBus.datapath),
		.fetchAddr(fetchAddr), .memReadData(memReadData), .aluResult(aluResult),
		.aluWrite(aluWrite), .operandValue(operandValue), .memAddr(memAddr),
		.memWriteData(memWriteData), .memWriteEnable(memWriteEnable));

	scratchAlu alu (.clock(clock), .reset(reset), .dp(uopBus.datapath),
		.operandValue(operandValue), .aluResult(aluResult), .aluWrite(aluWrite));

endmodule

// ==== rtl/microSequencer.sv ====
`timescale 1ns/1ps

module microSequencer
#(
	parameter int FlowCount = 72
)
(
	input  logic                              clock,
	input  logic                              reset,
	input  logic [cpuPkg::dataWidth-1:0]      memReadData,
	uopIf.sequencer                           seq,
	output logic                              fetchAddr,
	input  logic [cpuPkg::uopAddrWidth-1:0]   flowStart,
	output cpuPkg::opcode_t                   opcode,
	output logic [cpuPkg::uopAddrWidth-1:0]   uopAddr,
	input  cpuPkg::uop_t                      uop,
	output logic                              instructionEnd
);

	cpuPkg::seqState_t state;
	logic [cpuPkg::uopAddrWidth-1:0] uopAddrReg;
	logic executing;
	logic flowDone;
	logic lastWord;

	// Opcode byte is on the bus during decode
	assign opcode = cpuPkg::opcode_t'(memReadData);
	assign uopAddr = uopAddrReg;
	assign fetchAddr = (state == cpuPkg::seqFetchAddr);
	assign executing = (state == cpuPkg::seqExecute);
	assign lastWord = (uopAddrReg == FlowCount - 1);

	assign seq.uop = uop;
	assign seq.execValid = executing;

	////////////////////////////////////////////////////////////
	// End of flow, conditional ends test the zero flag here
	////////////////////////////////////////////////////////////
	always_comb
	begin
		case (uop.flow)
			cpuPkg::flowEnd,
			cpuPkg::flowIncPcEnd:     flowDone = 1'b1;
			cpuPkg::flowIncPcEndIfZ:  flowDone = seq.zeroFlag;
			cpuPkg::flowIncPcEndIfNz: flowDone = !seq.zeroFlag;
			default:                  flowDone = lastWord;
		endcase
	end

	assign instructionEnd = executing && flowDone;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= cpuPkg::seqFetchAddr;
			uopAddrReg <= '0;
		end
		else
		begin
			case (state)
				cpuPkg::seqFetchAddr: state <= cpuPkg::seqFetchWait;
				cpuPkg::seqFetchWait: state <= cpuPkg::seqDecode;
				cpuPkg::seqDecode:
				begin
					uopAddrReg <= flowStart;
					state <= cpuPkg::seqExecute;
				end
				default:
				begin
					if (flowDone)
						state <= cpuPkg::seqFetchAddr;
					else
						uopAddrReg <= uopAddrReg + 1'b1;
				end
			endcase
		end
	end

endmodule

// ==== rtl/microcodeRom.sv ====
`timescale 1ns/1ps

module microcodeRom
#(
	parameter int FlowCount = 72
)
(
	input  logic [cpuPkg::uopAddrWidth-1:0] uopAddr,
	output cpuPkg::uop_t                    uop
);

	function automatic cpuPkg::uop_t word(cpuPkg::uopFlow_t flow, cpuPkg::uopOp_t op,
		cpuPkg::regSel_t operand);
		word = '{flow: flow, op: op, operand: operand};
	endfunction

	always_comb
	begin
		uop = word(cpuPkg::flowEnd, cpuPkg::opNop, cpuPkg::regNone);
		if (uopAddr < FlowCount)
		begin
			case (uopAddr)
				// NOP
				0:  uop = word(cpuPkg::flowIncPcEnd, cpuPkg::opNop, cpuPkg::regNone);
				// LD r,n  (address follows the incremented PC)
				1:  uop = word(cpuPkg::flowIncPc, cpuPkg::opSetMemAddr, cpuPkg::regPc);
				2:  uop = word(cpuPkg::flowIncPc, cpuPkg::opNop, cpuPkg::regNone);
				3:  uop = word(cpuPkg::flowEnd, cpuPkg::opLoadFromMem, cpuPkg::regA);
				4:  uop = word(cpuPkg::flowIncPc, cpuPkg::opSetMemAddr, cpuPkg::regPc);
				5:  uop = word(cpuPkg::flowIncPc, cpuPkg::opNop, cpuPkg::regNone);
				6:  uop = word(cpuPkg::flowEnd, cpuPkg::opLoadFromMem, cpuPkg::regB);
				7:  uop = word(cpuPkg::flowIncPc, cpuPkg::opSetMemAddr, cpuPkg::regPc);
				8:  uop = word(cpuPkg::flowIncPc, cpuPkg::opNop, cpuPkg::regNone);
				9:  uop = word(cpuPkg::flowEnd, cpuPkg::opLoadFromMem, cpuPkg::regC);
				10: uop = word(cpuPkg::flowIncPc, cpuPkg::opSetMemAddr, cpuPkg::regPc);
				11: uop = word(cpuPkg::flowIncPc, cpuPkg::opNop, cpuPkg::regNone);
				12: uop = word(cpuPkg::flowEnd, cpuPkg::opLoadFromMem, cpuPkg::regD);
				13: uop = word(cpuPkg::flowIncPc, cpuPkg::opSetMemAddr, cpuPkg::regPc);
				14: uop = word(cpuPkg::flowIncPc, cpuPkg::opNop, cpuPkg::regNone);
				15: uop = word(cpuPkg::flowEnd, cpuPkg::opLoadFromMem, cpuPkg::regE);
				16: uop = word(cpuPkg::flowIncPc, cpuPkg::opSetMemAddr, cpuPkg::regPc);
				17: uop = word(cpuPkg::flowIncPc, cpuPkg::opNop, cpuPkg::regNone);
				18: uop = word(cpuPkg::flowEnd, cpuPkg::opLoadFromMem, cpuPkg::regH);
				19: uop = word(cpuPkg::flowIncPc, cpuPkg::opSetMemAddr, cpuPkg::regPc);
				20: uop = word(cpuPkg::flowIncPc, cpuPkg::opNop, cpuPkg::regNone);
				21: uop = word(cpuPkg::flowEnd, cpuPkg::opLoadFromMem, cpuPkg::regL);
				// LD HL,nn, low byte first
				22: uop = word(cpuPkg::flowIncPc, cpuPkg::opSetMemAddr, cpuPkg::regPc);
				23: uop = word(cpuPkg::flowIncPc, cpuPkg::opSetMemAddr, cpuPkg::regPc);
				24: uop = word(cpuPkg::flowIncPc, cpuPkg::opLoadFromMem, cpuPkg::regL);
				25: uop = word(cpuPkg::flowEnd, cpuPkg::opLoadFromMem, cpuPkg::regH);
				// INC r / DEC r
				26: uop = word(cpuPkg::flowUpdateFlags, cpuPkg::opInc, cpuPkg::regB);
				27: uop = word(cpuPkg::flowIncPcEnd, cpuPkg::opNop, cpuPkg::regNone);
				28: uop = word(cpuPkg::flowUpdateFlags, cpuPkg::opInc, cpuPkg::regC);
				29: uop = word(cpuPkg::flowIncPcEnd, cpuPkg::opNop, cpuPkg::regNone);
				30: uop = word(cpuPkg::flowUpdateFlags, cpuPkg::opInc, cpuPkg::regA);
				31: uop = word(cpuPkg::flowIncPcEnd, cpuPkg::opNop, cpuPkg::regNone);
				32: uop = word(cpuPkg::flowUpdateFlags, cpuPkg::opDec, cpuPkg::regB);
				33: uop = word(cpuPkg::flowIncPcEnd, cpuPkg::opNop, cpuPkg::regNone);
				34: uop = word(cpuPkg::flowUpdateFlags, cpuPkg::opDec, cpuPkg::regC);
				35: uop = word(cpuPkg::flowIncPcEnd, cpuPkg::opNop, cpuPkg::regNone);
				36: uop = word(cpuPkg::flowUpdateFlags, cpuPkg::opDec, cpuPkg::regA);
				37: uop = word(cpuPkg::flowIncPcEnd, cpuPkg::opNop, cpuPkg::regNone);
				// INC HL leaves the flags alone
				38: uop = word(cpuPkg::flowIncPcEnd, cpuPkg::opInc, cpuPkg::regHl);
				// ADD A,r / SUB r through the scratch register
				39: uop = word(cpuPkg::flowNext, cpuPkg::opLoadScratch, cpuPkg::regA);
				40: uop = word(cpuPkg::flowUpdateFlags, cpuPkg::opAddScratch, cpuPkg::regB);
				41: uop = word(cpuPkg::flowIncPcEnd, cpuPkg::opStoreScratch, cpuPkg::regA);
				42: uop = word(cpuPkg::flowNext, cpuPkg::opLoadScratch, cpuPkg::regA);
				43: uop = word(cpuPkg::flowUpdateFlags, cpuPkg::opAddScratch, cpuPkg::regC);
				44: uop = word(cpuPkg::flowIncPcEnd, cpuPkg::opStoreScratch, cpuPkg::regA);
				45: uop = word(cpuPkg::flowNext, cpuPkg::opLoadScratch, cpuPkg::regA);
				46: uop = word(cpuPkg::flowUpdateFlags, cpuPkg::opSubScratch, cpuPkg::regB);
				47: uop = word(cpuPkg::flowIncPcEnd, cpuPkg::opStoreScratch, cpuPkg::regA);
				48: uop = word(cpuPkg::flowNext, cpuPkg::opLoadScratch, cpuPkg::regA);
				49: uop = word(cpuPkg::flowUpdateFlags, cpuPkg::opSubScratch, cpuPkg::regC);
				50: uop = word(cpuPkg::flowIncPcEnd, cpuPkg::opStoreScratch, cpuPkg::regA);
				// JR: x16 = offset address + offset, then PC = x16 + 1
				51: uop = word(cpuPkg::flowIncPc, cpuPkg::opSetMemAddr, cpuPkg::regPc);
				52: uop = word(cpuPkg::flowIncPc, cpuPkg::opLoadScratch, cpuPkg::regPc);
				53: uop = word(cpuPkg::flowNext, cpuPkg::opAddScratch, cpuPkg::regX8);
				54: uop = word(cpuPkg::flowIncPcEnd, cpuPkg::opSetPc, cpuPkg::regX16);
				55: uop = word(cpuPkg::flowIncPc, cpuPkg::opSetMemAddr, cpuPkg::regPc);
				56: uop = word(cpuPkg::flowIncPcEndIfZ, cpuPkg::opLoadScratch, cpuPkg::regPc);
				57: uop = word(cpuPkg::flowNext, cpuPkg::opAddScratch, cpuPkg::regX8);
				58: uop = word(cpuPkg::flowIncPcEnd, cpuPkg::opSetPc, cpuPkg::regX16);
				59: uop = word(cpuPkg::flowIncPc, cpuPkg::opSetMemAddr, cpuPkg::regPc);
				60: uop = word(cpuPkg::flowIncPcEndIfNz, cpuPkg::opLoadScratch, cpuPkg::regPc);
				61: uop = word(cpuPkg::flowNext, cpuPkg::opAddScratch, cpuPkg::regX8);
				62: uop = word(cpuPkg::flowIncPcEnd, cpuPkg::opSetPc, cpuPkg::regX16);
				// LD (HL),r
				63: uop = word(cpuPkg::flowNext, cpuPkg::opSetMemAddr, cpuPkg::regHl);
				64: uop = word(cpuPkg::flowIncPcEnd, cpuPkg::opMemWrite, cpuPkg::regA);
				65: uop = word(cpuPkg::flowNext, cpuPkg::opSetMemAddr, cpuPkg::regHl);
				66: uop = word(cpuPkg::flowIncPcEnd, cpuPkg::opMemWrite, cpuPkg::regB);
				// LD A,(HL), one wait word for the read latency
				67: uop = word(cpuPkg::flowNext, cpuPkg::opSetMemAddr, cpuPkg::regHl);
				68: uop = word(cpuPkg::flowNext, cpuPkg::opNop, cpuPkg::regNone);
				69: uop = word(cpuPkg::flowIncPcEnd, cpuPkg::opLoadFromMem, cpuPkg::regA);
				default: uop = word(cpuPkg::flowEnd, cpuPkg::opNop, cpuPkg::regNone);
			endcase
		end
	end

endmodule

// ==== rtl/opcodeMap.sv ====
`timescale 1ns/1ps

module opcodeMap
(
	input  cpuPkg::opcode_t                 opcode,
	output logic [cpuPkg::uopAddrWidth-1:0] flowStart
);

	always_comb
	begin
		case (opcode)
			cpuPkg::mopLdAN:   flowStart = 9'd1;
			cpuPkg::mopLdBN:   flowStart = 9'd4;
			cpuPkg::mopLdCN:   flowStart = 9'd7;
			cpuPkg::mopLdDN:   flowStart = 9'd10;
			cpuPkg::mopLdEN:   flowStart = 9'd13;
			cpuPkg::mopLdHN:   flowStart = 9'd16;
			cpuPkg::mopLdLN:   flowStart = 9'd19;
			cpuPkg::mopLdHlNn: flowStart = 9'd22;
			cpuPkg::mopIncB:   flowStart = 9'd26;
			cpuPkg::mopIncC:   flowStart = 9'd28;
			cpuPkg::mopIncA:   flowStart = 9'd30;
			cpuPkg::mopDecB:   flowStart = 9'd32;
			cpuPkg::mopDecC:   flowStart = 9'd34;
			cpuPkg::mopDecA:   flowStart = 9'd36;
			cpuPkg::mopIncHl:  flowStart = 9'd38;
			cpuPkg::mopAddAB:  flowStart = 9'd39;
			cpuPkg::mopAddAC:  flowStart = 9'd42;
			cpuPkg::mopSubB:   flowStart = 9'd45;
			cpuPkg::mopSubC:   flowStart = 9'd48;
			cpuPkg::mopJrN:    flowStart = 9'd51;
			cpuPkg::mopJrNzN:  flowStart = 9'd55;
			cpuPkg::mopJrZN:   flowStart = 9'd59;
			cpuPkg::mopLdHlmA: flowStart = 9'd63;
			cpuPkg::mopLdHlmB: flowStart = 9'd65;
			cpuPkg::mopLdAHlm: flowStart = 9'd67;
			// Unknown opcodes run as a one byte NOP
			default:           flowStart = 9'd0;
		endcase
	end

endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/1ps

module registerFile
(
	input  logic                          clock,
	input  logic                          reset,
	uopIf.datapath                        dp,
	input  logic                          fetchAddr,
	input  logic [cpuPkg::dataWidth-1:0]  memReadData,
	input  logic [cpuPkg::addrWidth-1:0]  aluResult,
	input  logic                          aluWrite,
	output logic [cpuPkg::addrWidth-1:0]  operandValue,
	output logic [cpuPkg::addrWidth-1:0]  memAddr,
	output logic [cpuPkg::dataWidth-1:0]  memWriteData,
	output logic                          memWriteEnable
);

	logic [cpuPkg::dataWidth-1:0] a, b, c, d, e, h, l;
	logic [cpuPkg::addrWidth-1:0] pc, pcNext, memAddrReg;
	logic [cpuPkg::addrWidth-1:0] writeData;
	logic pcStep, loadMem, writeReg;

	always_comb
	begin
		case (dp.uop.operand)
			cpuPkg::regA:  operandValue = {8'h00, a};
			cpuPkg::regB:  operandValue = {8'h00, b};
			cpuPkg::regC:  operandValue = {8'h00, c};
			cpuPkg::regD:  operandValue = {8'h00, d};
			cpuPkg::regE:  operandValue = {8'h00, e};
			cpuPkg::regH:  operandValue = {8'h00, h};
			cpuPkg::regL:  operandValue = {8'h00, l};
			cpuPkg::regHl: operandValue = {h, l};
			cpuPkg::regPc: operandValue = pc;
			cpuPkg::regX8: operandValue = {8'h00, memReadData};
			default:       operandValue = '0;
		endcase
	end

	// Increment applies on top of a PC load
	assign pcStep = dp.execValid && (dp.uop.flow inside {cpuPkg::flowIncPc,
		cpuPkg::flowIncPcEnd, cpuPkg::flowIncPcEndIfZ, cpuPkg::flowIncPcEndIfNz});
	assign pcNext = ((dp.execValid && dp.uop.op == cpuPkg::opSetPc) ? aluResult : pc)
		+ {15'd0, pcStep};

	assign loadMem = dp.execValid && (dp.uop.op == cpuPkg::opLoadFromMem);
	assign writeReg = loadMem || aluWrite;
	assign writeData = loadMem ? {8'h00, memReadData} : aluResult;

	assign memAddr = memAddrReg;
	assign memWriteData = operandValue[7:0];
	assign memWriteEnable = dp.execValid && (dp.uop.op == cpuPkg::opMemWrite);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			{a, b, c, d, e, h, l} <= '0;
			pc <= '0;
			memAddrReg <= '0;
		end
		else
		begin
			pc <= pcNext;
			if (fetchAddr)
				memAddrReg <= pc;
			else if (dp.execValid && dp.uop.op == cpuPkg::opSetMemAddr)
				memAddrReg <= (dp.uop.operand == cpuPkg::regPc) ? pcNext : operandValue;
			if (writeReg)
			begin
				case (dp.uop.operand)
					cpuPkg::regA:  a <= writeData[7:0];
					cpuPkg::regB:  b <= writeData[7:0];
					cpuPkg::regC:  c <= writeData[7:0];
					cpuPkg::regD:  d <= writeData[7:0];
					cpuPkg::regE:  e <= writeData[7:0];
					cpuPkg::regH:  h <= writeData[7:0];
					cpuPkg::regL:  l <= writeData[7:0];
					cpuPkg::regHl: {h, l} <= writeData;
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== rtl/scratchAlu.sv ====
`timescale 1ns/1ps

module scratchAlu
(
	input  logic                          clock,
	input  logic                          reset,
	uopIf.datapath                        dp,
	input  logic [cpuPkg::addrWidth-1:0]  operandValue,
	output logic [cpuPkg::addrWidth-1:0]  aluResult,
	output logic                          aluWrite
);

	logic [cpuPkg::addrWidth-1:0] scratch, addend;
	logic [8:0] flagCalc;
	logic zero, carry;

	// Memory bytes are signed offsets, registers are unsigned
	assign addend = (dp.uop.operand == cpuPkg::regX8) ?
		{{8{operandValue[7]}}, operandValue[7:0]} : operandValue;

	always_comb
	begin
		case (dp.uop.op)
			cpuPkg::opInc: aluResult = operandValue + 16'd1;
			cpuPkg::opDec: aluResult = operandValue - 16'd1;
			default:       aluResult = scratch;
		endcase
	end

	assign aluWrite = dp.execValid && (dp.uop.op inside {cpuPkg::opInc, cpuPkg::opDec,
		cpuPkg::opStoreScratch});

	// 8-bit view for Z and the carry out of bit 7
	always_comb
	begin
		case (dp.uop.op)
			cpuPkg::opAddScratch: flagCalc = {1'b0, scratch[7:0]} + {1'b0, operandValue[7:0]};
			cpuPkg::opSubScratch: flagCalc = {1'b0, scratch[7:0]} - {1'b0, operandValue[7:0]};
			cpuPkg::opInc:        flagCalc = {1'b0, operandValue[7:0]} + 9'd1;
			cpuPkg::opDec:        flagCalc = {1'b0, operandValue[7:0]} - 9'd1;
			default:              flagCalc = {carry, 7'd0, !zero};
		endcase
	end

	assign dp.zeroFlag = zero;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			scratch <= '0;
			zero <= 1'b0;
			carry <= 1'b0;
		end
		else if (dp.execValid)
		begin
			case (dp.uop.op)
				cpuPkg::opLoadScratch: scratch <= operandValue;
				cpuPkg::opAddScratch:  scratch <= scratch + addend;
				cpuPkg::opSubScratch:  scratch <= scratch - operandValue;
				default: ;
			endcase
			if (dp.uop.flow == cpuPkg::flowUpdateFlags)
			begin
				zero <= (flagCalc[7:0] == 8'h00);
				carry <= flagCalc[8];
			end
		end
	end

endmodule

// ==== rtl/uopIf.sv ====
`timescale 1ns/1ps

// Current microinstruction from the sequencer, zero flag back from the ALU
interface uopIf;

	cpuPkg::uop_t uop;
	logic execValid;
	logic zeroFlag;

	modport sequencer
	(
		output uop,
		output execValid,
		input  zeroFlag
	);

	modport datapath
	(
		input  uop,
		input  execValid,
		output zeroFlag
	);

endinterface

// ==== vlog.f ====
rtl/cpuPkg.sv
rtl/uopIf.sv
rtl/opcodeMap.sv
rtl/microcodeRom.sv
rtl/microSequencer.sv
rtl/registerFile.sv
rtl/scratchAlu.sv
rtl/gbCpuCore.sv
bench/cpuCore_asserts.sv
bench/tbCpu.sv
